// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = mipsExecCore_tb
FILELIST  = mipsExecCore.f
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== mipsExecCore.f ====
src/mipsPkg.sv
src/instrDecoder.sv
src/alu.sv
src/mulUnit.sv
src/regFile.sv
src/apbIssuePort.sv
src/mipsExecCore.sv
verification/mipsExecCore_asserts.sv
verification/mipsExecCore_tb.sv

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  mipsPkg::ctrlT                      ctrl,
    input  mipsPkg::instrT                     instr,
    input  logic                               issue,
    input  logic [mipsPkg::DataWidth-1:0]      rsData,
    input  logic [mipsPkg::DataWidth-1:0]      rtData,
    input  logic [2*mipsPkg::DataWidth-1:0]    hiLo,
    output logic [mipsPkg::DataWidth-1:0]      wbData,
    output logic                               wbEn
);

    import mipsPkg::*;

    logic [DataWidth-1:0] immExt;
    logic [DataWidth-1:0] opB;
    logic [4:0]           shAmt;
    logic                 moveOk;

    always_comb
    begin
        if (ctrl.shiftSel)
            immExt = {instr[15:0], 16'h0000};
        else if (ctrl.func inside {FnAddi, FnSlti, FnSltiu})
            immExt = {{16{instr[15]}}, instr[15:0]};
        else
            immExt = {16'h0000, instr[15:0]};
    end

    assign opB   = ctrl.aluSrc ? immExt : rtData;
    assign shAmt = (ctrl.func inside {FnSllv, FnSrlv, FnSrav}) ? rsData[4:0] : instr.shamt;

    always_comb
    begin
        case (ctrl.func)
            FnAdd, FnAddu, FnAddi: wbData = rsData + opB;
            FnSub, FnSubu:         wbData = rsData - opB;
            FnSll, FnSllv:         wbData = opB << shAmt;
            FnSrl, FnSrlv:         wbData = opB >> shAmt;
            FnSra, FnSrav:         wbData = $signed(opB) >>> shAmt;
            FnAnd, FnAndi:         wbData = rsData & opB;
            FnOr, FnOri:           wbData = rsData | opB;
            FnXor, FnXori:         wbData = rsData ^ opB;
            FnNor:                 wbData = ~(rsData | opB);
            FnSlt, FnSlti:
                wbData = {{(DataWidth-1){1'b0}}, $signed(rsData) < $signed(opB)};
            FnSltu, FnSltiu:
                wbData = {{(DataWidth-1){1'b0}}, rsData < opB};
            FnMovn, FnMovz:        wbData = rsData;
            FnMfhi:                wbData = hiLo[2*DataWidth-1:DataWidth];
            FnMflo:                wbData = hiLo[DataWidth-1:0];
            FnLui:                 wbData = opB;
            default:               wbData = '0;
        endcase
    end

    // Conditional moves drop the write when rt fails the test.
    always_comb
    begin
        case (ctrl.func)
            FnMovn:  moveOk = |rtData;
            FnMovz:  moveOk = ~|rtData;
            default: moveOk = 1'b1;
        endcase
    end

    assign wbEn = issue && ctrl.aluOp && ctrl.regWrite && moveOk;

endmodule

// ==== src/apbIssuePort.sv ====
`timescale 1ns/1ps

module apbIssuePort (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               pSel,
    input  logic                               pEnable,
    input  logic                               pWrite,
    input  logic [11:0]                        pAddr,
    input  logic [mipsPkg::DataWidth-1:0]      pWData,
    output logic [mipsPkg::DataWidth-1:0]      pRData,
    output logic                               pReady,
    output logic                               pSlvErr,
    output mipsPkg::instrT                     instr,
    output logic                               issue,
    input  mipsPkg::ctrlT                      ctrl,
    input  logic                               busy,
    input  logic [2*mipsPkg::DataWidth-1:0]    hiLo,
    output logic [4:0]                         apbAddr,
    output logic [mipsPkg::DataWidth-1:0]      apbWData,
    output logic                               apbWrEn,
    input  logic [mipsPkg::DataWidth-1:0]      apbRData
);

    import mipsPkg::*;

    logic access;
    logic isInstr;
    logic isHi;
    logic isLo;
    logic isReg;
    logic mulStall;
    logic issued;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address decode.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign access  = pSel && pEnable;
    assign isInstr = (pAddr == AddrInstr);
    assign isHi    = (pAddr == AddrHi);
    assign isLo    = (pAddr == AddrLo);
    assign isReg   = ((pAddr & ~12'h07c) == AddrRegBase);

    assign apbAddr  = pAddr[6:2];
    assign apbWData = pWData;
    assign apbWrEn  = access && pWrite && isReg;

    // Multiply-class ops hold the bus. MTHI and MTLO finish at once.
    assign mulStall = ctrl.mulOp && !(ctrl.func inside {FnMthi, FnMtlo});
    assign issue    = access && pWrite && isInstr && !issued && ctrl.valid;

    // Instruction is captured in the setup cycle for decode in the access cycle.
    always_ff @(posedge clk)
    begin
        if (pSel && !pEnable && pWrite && isInstr)
            instr <= instrT'(pWData);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            issued <= 1'b0;
        else if (issue)
            issued <= mulStall;
        else if (access && pReady)
            issued <= 1'b0;
    end

    // HI and LO are loaded through MTHI and MTLO. Their APB view is read-only.
    always_comb
    begin
        pReady  = 1'b0;
        pSlvErr = 1'b0;
        pRData  = '0;
        if (access)
        begin
            pReady = 1'b1;
            if (isInstr)
            begin
                pRData = instr;
                if (pWrite && issued)
                    pReady = !busy;
                else if (pWrite && !ctrl.valid)
                    pSlvErr = 1'b1;
                else if (pWrite && mulStall)
                    pReady = 1'b0;
            end
            else if (isHi && !pWrite)
                pRData = hiLo[2*DataWidth-1:DataWidth];
            else if (isLo && !pWrite)
                pRData = hiLo[DataWidth-1:0];
            else if (isReg)
                pRData = apbRData;
            else
                pSlvErr = 1'b1;
        end
    end

endmodule

// ==== src/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
    input  mipsPkg::instrT instr,
    output mipsPkg::ctrlT  ctrl
);

    import mipsPkg::*;

    // Common control word for the immediate forms.
    function automatic ctrlT immCtrl(input funcE f);
        ctrlT c;
        c          = '0;
        c.valid    = 1'b1;
        c.aluOp    = 1'b1;
        c.aluSrc   = 1'b1;
        c.regWrite = 1'b1;
        c.shiftSel = (f == FnLui);
        c.func     = f;
        return c;
    endfunction

    always_comb
    begin
        ctrl = '0;

        case (instr.opcode)
            OpAlu:
                case (instr.funct)
                    FnAdd, FnAddu, FnSub, FnSubu,
                    FnSll, FnSllv, FnSra, FnSrav, FnSrl, FnSrlv,
                    FnAnd, FnOr, FnXor, FnNor,
                    FnSlt, FnSltu, FnMovn, FnMovz,
                    FnMfhi, FnMflo:
                    begin
                        ctrl.valid    = 1'b1;
                        ctrl.regDst   = 1'b1;
                        ctrl.aluOp    = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.func     = funcE'(instr.funct);
                    end

                    // HI/LO writers live in the multiplier.
                    FnMult, FnMultu, FnMthi, FnMtlo:
                    begin
                        ctrl.valid = 1'b1;
                        ctrl.mulOp = 1'b1;
                        ctrl.func  = funcE'(instr.funct);
                    end

                    default:;
                endcase

            OpMull:
            begin
                ctrl.valid = 1'b1;
                ctrl.mulOp = 1'b1;
                case (instr.funct)
                    Sp2Madd:  ctrl.func = FnMadd;
                    Sp2Maddu: ctrl.func = FnMaddu;
                    Sp2Msub:  ctrl.func = FnMsub;
                    Sp2Msubu: ctrl.func = FnMsubu;

                    Sp2Mul:
                    begin
                        ctrl.func     = FnMul;
                        ctrl.regDst   = 1'b1;
                        ctrl.regWrite = 1'b1;
                    end

                    // CLO, CLZ and anything else.
                    default:
                    begin
                        ctrl.valid = 1'b0;
                        ctrl.mulOp = 1'b0;
                    end
                endcase
            end

            OpAddi, OpAddiu: ctrl = immCtrl(FnAddi);
            OpSlti:          ctrl = immCtrl(FnSlti);
            OpSltiu:         ctrl = immCtrl(FnSltiu);
            OpAndi:          ctrl = immCtrl(FnAndi);
            OpOri:           ctrl = immCtrl(FnOri);
            OpXori:          ctrl = immCtrl(FnXori);
            OpLui:           ctrl = immCtrl(FnLui);

            default:;
        endcase
    end

endmodule

// ==== src/mipsExecCore.sv ====
`timescale 1ns/1ps

module mipsExecCore (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pSel,
    input  logic                          pEnable,
    input  logic                          pWrite,
    input  logic [11:0]                   pAddr,
    input  logic [mipsPkg::DataWidth-1:0] pWData,
    output logic [mipsPkg::DataWidth-1:0] pRData,
    output logic                          pReady,
    output logic                          pSlvErr
);

    import mipsPkg::*;

    instrT                  instr;
    ctrlT                   ctrl;
    mulWbT                  mulWb;
    logic                   issue;
    logic                   busy;
    logic                   wbEn;
    logic                   apbWrEn;
    logic [4:0]             apbAddr;
    logic [4:0]             wrAddr;
    logic                   wrEn;
    logic [DataWidth-1:0]   wrData;
    logic [DataWidth-1:0]   rsData;
    logic [DataWidth-1:0]   rtData;
    logic [DataWidth-1:0]   wbData;
    logic [DataWidth-1:0]   apbWData;
    logic [DataWidth-1:0]   apbRData;
    logic [2*DataWidth-1:0] hiLo;

    // Write-back steering between the ALU and the MUL result.
    assign wrAddr = ctrl.regDst ? instr.rd : instr.rt;
    assign wrData = mulWb.en ? mulWb.data : wbData;
    assign wrEn   = wbEn || mulWb.en;

    apbIssuePort apbIssuePort_i (
        .clk      (clk),
        .rst      (rst),
        .pSel     (pSel),
        .pEnable  (pEnable),
        .pWrite   (pWrite),
        .pAddr    (pAddr),
        .pWData   (pWData),
        .pRData   (pRData),
        .pReady   (pReady),
        .pSlvErr  (pSlvErr),
        .instr    (instr),
        .issue    (issue),
        .ctrl     (ctrl),
        .busy     (busy),
        .hiLo     (hiLo),
        .apbAddr  (apbAddr),
        .apbWData (apbWData),
        .apbWrEn  (apbWrEn),
        .apbRData (apbRData)
    );

    instrDecoder instrDecoder_i (
        .instr (instr),
        .ctrl  (ctrl)
    );

    alu alu_i (
        .ctrl   (ctrl),
        .instr  (instr),
        .issue  (issue),
        .rsData (rsData),
        .rtData (rtData),
        .hiLo   (hiLo),
        .wbData (wbData),
        .wbEn   (wbEn)
    );

    mulUnit mulUnit_i (
        .clk    (clk),
        .rst    (rst),
        .issue  (issue),
        .ctrl   (ctrl),
        .rsData (rsData),
        .rtData (rtData),
        .busy   (busy),
        .hiLo   (hiLo),
        .mulWb  (mulWb)
    );

    regFile regFile_i (
        .clk      (clk),
        .rst      (rst),
        .rsAddr   (instr.rs),
        .rtAddr   (instr.rt),
        .rsData   (rsData),
        .rtData   (rtData),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .wrEn     (wrEn),
        .apbAddr  (apbAddr),
        .apbWData (apbWData),
        .apbWrEn  (apbWrEn),
        .apbRData (apbRData)
    );

endmodule

// ==== src/mipsPkg.sv ====
package mipsPkg;

    localparam int DataWidth = 32;
    localparam int MulSteps  = 32;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB address map.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [11:0] AddrInstr   = 12'h000;
    localparam logic [11:0] AddrHi      = 12'h004;
    localparam logic [11:0] AddrLo      = 12'h008;
    localparam logic [11:0] AddrRegBase = 12'h080;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction encodings.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [5:0] {
        OpAlu   = 6'h00,
        OpAddi  = 6'h08,
        OpAddiu = 6'h09,
        OpSlti  = 6'h0a,
        OpSltiu = 6'h0b,
        OpAndi  = 6'h0c,
        OpOri   = 6'h0d,
        OpXori  = 6'h0e,
        OpLui   = 6'h0f,
        OpMull  = 6'h1c
    } opcodeE;

    // SPECIAL2 function field values as they sit in the instruction word.
    localparam logic [5:0] Sp2Madd  = 6'h00;
    localparam logic [5:0] Sp2Maddu = 6'h01;
    localparam logic [5:0] Sp2Mul   = 6'h02;
    localparam logic [5:0] Sp2Msub  = 6'h04;
    localparam logic [5:0] Sp2Msubu = 6'h05;

    // SPECIAL codes keep their own value. SPECIAL2 ops move to 6'h38 + code
    // and the immediate forms to 6'h30 + opcode[2:0].
    typedef enum logic [5:0] {
        FnSll   = 6'h00,
        FnSrl   = 6'h02,
        FnSra   = 6'h03,
        FnSllv  = 6'h04,
        FnSrlv  = 6'h06,
        FnSrav  = 6'h07,
        FnMovz  = 6'h0a,
        FnMovn  = 6'h0b,
        FnMfhi  = 6'h10,
        FnMthi  = 6'h11,
        FnMflo  = 6'h12,
        FnMtlo  = 6'h13,
        FnMult  = 6'h18,
        FnMultu = 6'h19,
        FnAdd   = 6'h20,
        FnAddu  = 6'h21,
        FnSub   = 6'h22,
        FnSubu  = 6'h23,
        FnAnd   = 6'h24,
        FnOr    = 6'h25,
        FnXor   = 6'h26,
        FnNor   = 6'h27,
        FnSlt   = 6'h2a,
        FnSltu  = 6'h2b,
        FnAddi  = 6'h30,
        FnSlti  = 6'h32,
        FnSltiu = 6'h33,
        FnAndi  = 6'h34,
        FnOri   = 6'h35,
        FnXori  = 6'h36,
        FnLui   = 6'h37,
        FnMadd  = 6'h38,
        FnMaddu = 6'h39,
        FnMul   = 6'h3a,
        FnMsub  = 6'h3c,
        FnMsubu = 6'h3d
    } funcE;

    typedef struct packed {
        opcodeE     opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instrT;

    typedef struct packed {
        logic valid;
        logic regDst;
        logic aluOp;
        logic mulOp;
        logic aluSrc;
        logic regWrite;
        logic shiftSel;
        funcE func;
    } ctrlT;

    typedef struct packed {
        logic                 en;
        logic [DataWidth-1:0] data;
    } mulWbT;

endpackage

// ==== src/mulUnit.sv ====
`timescale 1ns/1ps

module mulUnit (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               issue,
    input  mipsPkg::ctrlT                      ctrl,
    input  logic [mipsPkg::DataWidth-1:0]      rsData,
    input  logic [mipsPkg::DataWidth-1:0]      rtData,
    output logic                               busy,
    output logic [2*mipsPkg::DataWidth-1:0]    hiLo,
    output mipsPkg::mulWbT                     mulWb
);

    import mipsPkg::*;

    logic [DataWidth-1:0]        hi;
    logic [DataWidth-1:0]        lo;
    logic [2*DataWidth-1:0]      acc;
    logic [2*DataWidth-1:0]      mcand;
    logic [2*DataWidth-1:0]      accNext;
    logic [2*DataWidth-1:0]      product;
    logic [DataWidth-1:0]        mplier;
    logic [DataWidth-1:0]        magA;
    logic [DataWidth-1:0]        magB;
    logic [$clog2(MulSteps)-1:0] step;
    logic                        neg;
    logic                        isSigned;
    logic                        start;
    logic                        last;
    funcE                        op;

    assign isSigned = ctrl.func inside {FnMult, FnMadd, FnMsub, FnMul};
    assign start    = issue && ctrl.mulOp && !(ctrl.func inside {FnMthi, FnMtlo});
    assign last     = busy && (int'(step) == MulSteps - 1);

    // Work on magnitudes. The sign is restored on the final sum.
    assign magA = (isSigned && rsData[DataWidth-1]) ? -rsData : rsData;
    assign magB = (isSigned && rtData[DataWidth-1]) ? -rtData : rtData;

    assign accNext = acc + (mplier[0] ? mcand : '0);
    assign product = neg ? -accNext : accNext;

    assign hiLo       = {hi, lo};
    assign mulWb.en   = last && (op == FnMul);
    assign mulWb.data = product[DataWidth-1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencing and HI/LO.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            step <= '0;
            hi   <= '0;
            lo   <= '0;
        end
        else
        begin
            if (start)
            begin
                busy <= 1'b1;
                step <= '0;
            end
            else if (busy)
            begin
                step <= step + 1'b1;
                if (last)
                    busy <= 1'b0;
            end

            if (issue && ctrl.mulOp && ctrl.func == FnMthi)
                hi <= rsData;
            if (issue && ctrl.mulOp && ctrl.func == FnMtlo)
                lo <= rsData;

            // MUL leaves HI/LO alone.
            if (last)
                case (op)
                    FnMult, FnMultu: {hi, lo} <= product;
                    FnMadd, FnMaddu: {hi, lo} <= hiLo + product;
                    FnMsub, FnMsubu: {hi, lo} <= hiLo - product;
                    default:;
                endcase
        end
    end

    // Shift-and-add datapath.
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            op     <= ctrl.func;
            neg    <= isSigned && (rsData[DataWidth-1] ^ rtData[DataWidth-1]);
            acc    <= '0;
            mcand  <= {{DataWidth{1'b0}}, magA};
            mplier <= magB;
        end
        else if (busy)
        begin
            acc    <= accNext;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [4:0]                    rsAddr,
    input  logic [4:0]                    rtAddr,
    output logic [mipsPkg::DataWidth-1:0] rsData,
    output logic [mipsPkg::DataWidth-1:0] rtData,
    input  logic [4:0]                    wrAddr,
    input  logic [mipsPkg::DataWidth-1:0] wrData,
    input  logic                          wrEn,
    input  logic [4:0]                    apbAddr,
    input  logic [mipsPkg::DataWidth-1:0] apbWData,
    input  logic                          apbWrEn,
    output logic [mipsPkg::DataWidth-1:0] apbRData
);

    import mipsPkg::*;

    logic [DataWidth-1:0] regs [32];

    // Register 0 is never written, so it stays at its reset value of zero.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wrEn && wrAddr != 5'd0)
            regs[wrAddr] <= wrData;
        else if (apbWrEn && apbAddr != 5'd0)
            regs[apbAddr] <= apbWData;
    end

    assign rsData   = regs[rsAddr];
    assign rtData   = regs[rtAddr];
    assign apbRData = regs[apbAddr];

endmodule

// ==== verification/mipsExecCore_asserts.sv ====
`timescale 1ns/1ps

module mipsExecCore_asserts (
    input logic clk,
    input logic rst,
    input logic pSel,
    input logic pEnable,
    input logic pReady,
    input logic pSlvErr,
    input logic issue,
    input logic busy
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB response rules.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    readyInAccess: assert property (@(posedge clk) disable iff (rst)
        pReady |-> (pSel && pEnable))
        else $error("pReady high outside an access cycle");

    errWithReady: assert property (@(posedge clk) disable iff (rst)
        pSlvErr |-> pReady)
        else $error("pSlvErr high without pReady");

    // Execute strobe and multiplier stall.
    issuePulse: assert property (@(posedge clk) disable iff (rst)
        issue |=> !issue)
        else $error("issue held for more than one cycle");

    stallWhileBusy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !pReady)
        else $error("pReady high while the multiplier is busy");

endmodule

bind apbIssuePort mipsExecCore_asserts mipsExecCore_asserts_i (
    .clk     (clk),
    .rst     (rst),
    .pSel    (pSel),
    .pEnable (pEnable),
    .pReady  (pReady),
    .pSlvErr (pSlvErr),
    .issue   (issue),
    .busy    (busy)
);

// ==== verification/mipsExecCore_tb.sv ====
`timescale 1ns/1ps

module mipsExecCore_tb;

    import mipsPkg::*;

    localparam int ClkPeriod = 100;
    // Upper bound on the APB transfers issued by all tests together.
    localparam int MaxXfers  = 400;

    logic        clk;
    logic        rst;
    logic        pSel;
    logic        pEnable;
    logic        pWrite;
    logic [11:0] pAddr;
    logic [31:0] pWData;
    logic [31:0] pRData;
    logic        pReady;
    logic        pSlvErr;

    logic [31:0] model [32];
    logic [31:0] hiM;
    logic [31:0] loM;
    logic [31:0] expRData;
    logic        expErr;
    logic        checkRead;
    integer      seed;
    int          errors;
    int          checks;
    int          waits;
    int          errBefore;

    mipsExecCore mipsExecCore_i (
        .clk     (clk),
        .rst     (rst),
        .pSel    (pSel),
        .pEnable (pEnable),
        .pWrite  (pWrite),
        .pAddr   (pAddr),
        .pWData  (pWData),
        .pRData  (pRData),
        .pReady  (pReady),
        .pSlvErr (pSlvErr)
    );

    initial
    begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks on every completed transfer.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assert property (@(posedge clk) disable iff (rst)
        (pSel && pEnable && pReady && checkRead) |-> (pRData == expRData))
    else
    begin
        $display("** Error at %0t ns: pRData = %08h, expected %08h",
                 $time, $sampled(pRData), $sampled(expRData));
        errors++;
    end

    assert property (@(posedge clk) disable iff (rst)
        (pSel && pEnable && pReady) |-> (pSlvErr == expErr))
    else
    begin
        $display("** Error at %0t ns: pSlvErr = %0b, expected %0b",
                 $time, $sampled(pSlvErr), $sampled(expErr));
        errors++;
    end

    initial
    begin
        #(MaxXfers * (MulSteps + 4) * ClkPeriod);
        $display("Watchdog expired: the tests did not finish in time");
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    // Reference results for the SPECIAL group.
    function automatic logic [31:0] rTypeRef(input logic [5:0] fn, input logic [31:0] a,
                                             input logic [31:0] b, input logic [4:0] sa);
        case (fn)
            FnAdd, FnAddu: return a + b;
            FnSub, FnSubu: return a - b;
            FnSll:         return b << sa;
            FnSllv:        return b << a[4:0];
            FnSrl:         return b >> sa;
            FnSrlv:        return b >> a[4:0];
            FnSra:         return $signed(b) >>> sa;
            FnSrav:        return $signed(b) >>> a[4:0];
            FnAnd:         return a & b;
            FnOr:          return a | b;
            FnXor:         return a ^ b;
            FnNor:         return ~(a | b);
            FnSlt:         return {31'd0, $signed(a) < $signed(b)};
            FnSltu:        return {31'd0, a < b};
            default:       return a;
        endcase
    endfunction

    function automatic logic [31:0] immRef(input logic [5:0] op, input logic [31:0] a,
                                           input logic [15:0] imm);
        logic [31:0] se;
        logic [31:0] ze;
        se = {{16{imm[15]}}, imm};
        ze = {16'h0000, imm};
        case (op)
            OpAddi, OpAddiu: return a + se;
            OpSlti:          return {31'd0, $signed(a) < $signed(se)};
            OpSltiu:         return {31'd0, a < se};
            OpAndi:          return a & ze;
            OpOri:           return a | ze;
            OpXori:          return a ^ ze;
            default:         return {imm, 16'h0000};
        endcase
    endfunction

    // Full 64-bit product, sign-extending the operands when signed.
    function automatic logic [63:0] productRef(input logic [31:0] a, input logic [31:0] b,
                                               input logic sgn);
        logic [63:0] wa;
        logic [63:0] wb;
        wa = sgn ? {{32{a[31]}}, a} : {32'd0, a};
        wb = sgn ? {{32{b[31]}}, b} : {32'd0, b};
        return wa * wb;
    endfunction

    function automatic logic [31:0] mulWord(input logic [5:0] fn, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [4:0] rd);
        case (fn)
            FnMult:  return {OpAlu, rs, rt, 10'd0, 6'(FnMult)};
            FnMultu: return {OpAlu, rs, rt, 10'd0, 6'(FnMultu)};
            FnMadd:  return {OpMull, rs, rt, 10'd0, Sp2Madd};
            FnMaddu: return {OpMull, rs, rt, 10'd0, Sp2Maddu};
            FnMsub:  return {OpMull, rs, rt, 10'd0, Sp2Msub};
            FnMsubu: return {OpMull, rs, rt, 10'd0, Sp2Msubu};
            default: return {OpMull, rs, rt, rd, 5'd0, Sp2Mul};
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB master.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic xfer(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                        input logic [31:0] expData, input logic err);
        @(negedge clk);
        pSel      = 1'b1;
        pEnable   = 1'b0;
        pWrite    = wr;
        pAddr     = addr;
        pWData    = data;
        expRData  = expData;
        expErr    = err;
        checkRead = !wr && !err;
        @(negedge clk);
        pEnable = 1'b1;
        waits   = 0;
        @(posedge clk);
        while (!pReady)
        begin
            waits++;
            @(posedge clk);
        end
        checks = checks + (checkRead ? 2 : 1);
        @(negedge clk);
        pSel      = 1'b0;
        pEnable   = 1'b0;
        checkRead = 1'b0;
    endtask

    task automatic writeReg(input int r, input logic [31:0] v);
        xfer(1'b1, AddrRegBase + 12'(4 * r), v, '0, 1'b0);
        if (r != 0)
            model[r] = v;
    endtask

    task automatic checkReg(input int r);
        xfer(1'b0, AddrRegBase + 12'(4 * r), '0, model[r], 1'b0);
    endtask

    task automatic checkHiLo();
        xfer(1'b0, AddrHi, '0, hiM, 1'b0);
        xfer(1'b0, AddrLo, '0, loM, 1'b0);
    endtask

    task automatic issueInstr(input logic [31:0] word);
        xfer(1'b1, AddrInstr, word, '0, 1'b0);
    endtask

    task automatic endTest(input string name);
        $display("%-10s finished with %0d errors", name, errors - errBefore);
        errBefore = errors;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic regTest();
        for (int r = 0; r < 32; r++)
            writeReg(r, rnd());
        for (int r = 0; r < 32; r++)
            checkReg(r);
        writeReg(0, 32'hffff_ffff);
        checkReg(0);
    endtask

    task automatic aluTest();
        logic [5:0]  fns [18];
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic [31:0] res;
        fns = '{FnAdd, FnAddu, FnSub, FnSubu, FnSll, FnSllv, FnSra, FnSrav, FnSrl,
                FnSrlv, FnAnd, FnOr, FnXor, FnNor, FnSlt, FnSltu, FnMovn, FnMovz};
        for (int i = 0; i < 36; i++)
        begin
            fn = fns[i % 18];
            rs = 5'(rnd());
            rt = 5'(rnd());
            rd = 5'(rnd());
            sa = 5'(rnd());
            // Second pass gives the conditional moves a zero rt.
            if (i >= 18 && (fn == FnMovn || fn == FnMovz))
                rt = 5'd0;
            res = rTypeRef(fn, model[rs], model[rt], sa);
            issueInstr({OpAlu, rs, rt, rd, sa, fn});
            if (rd != 0 && !(fn == FnMovn && model[rt] == 0)
                        && !(fn == FnMovz && model[rt] != 0))
                model[rd] = res;
            checkReg(rd);
        end
    endtask

    task automatic immTest();
        logic [5:0]  ops [8];
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
        ops = '{OpAddi, OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori, OpLui};
        for (int i = 0; i < 24; i++)
        begin
            op  = ops[i % 8];
            rs  = 5'(rnd());
            rt  = 5'(rnd());
            imm = 16'(rnd());
            issueInstr({op, rs, rt, imm});
            if (rt != 0)
                model[rt] = immRef(op, model[rs], imm);
            checkReg(rt);
        end
    endtask

    task automatic mulTest();
        logic [5:0]  fns [7];
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [63:0] p;
        fns = '{FnMult, FnMultu, FnMadd, FnMaddu, FnMsub, FnMsubu, FnMul};
        for (int i = 0; i < 14; i++)
        begin
            fn = fns[i % 7];
            rs = 5'(rnd());
            rt = 5'(rnd());
            rd = 5'(rnd());
            p  = productRef(model[rs], model[rt], fn inside {FnMult, FnMadd, FnMsub, FnMul});
            issueInstr(mulWord(fn, rs, rt, rd));
            assert (waits > 0)
            else
            begin
                $display("%0t ns: multiply %02h completed without a wait state", $time, fn);
                errors++;
            end
            case (fn)
                FnMult, FnMultu: {hiM, loM} = p;
                FnMadd, FnMaddu: {hiM, loM} = {hiM, loM} + p;
                FnMsub, FnMsubu: {hiM, loM} = {hiM, loM} - p;
                default:
                    if (rd != 0)
                        model[rd] = p[31:0];
            endcase
            checkHiLo();
            if (fn == FnMul)
                checkReg(rd);
        end
    endtask

    task automatic hiLoTest();
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        for (int i = 0; i < 4; i++)
        begin
            rs = 5'(rnd());
            rt = 5'(rnd());
            issueInstr({OpAlu, rs, 15'd0, 6'(FnMthi)});
            hiM = model[rs];
            issueInstr({OpAlu, rt, 15'd0, 6'(FnMtlo)});
            loM = model[rt];
            checkHiLo();
            rd = 5'(rnd());
            issueInstr({OpAlu, 10'd0, rd, 5'd0, 6'(FnMfhi)});
            if (rd != 0)
                model[rd] = hiM;
            checkReg(rd);
            rd = 5'(rnd());
            issueInstr({OpAlu, 10'd0, rd, 5'd0, 6'(FnMflo)});
            if (rd != 0)
                model[rd] = loM;
            checkReg(rd);
        end
    endtask

    task automatic errorTest();
        // BEQ, then CLZ, then unmapped write and read.
        xfer(1'b1, AddrInstr, {6'h04, 5'd1, 5'd2, 16'h0010}, '0, 1'b1);
        xfer(1'b1, AddrInstr, {OpMull, 5'd3, 5'd4, 5'd4, 5'd0, 6'h20}, '0, 1'b1);
        xfer(1'b1, 12'h010, rnd(), '0, 1'b1);
        xfer(1'b0, 12'h200, '0, '0, 1'b1);
        for (int r = 0; r < 32; r++)
            checkReg(r);
        checkHiLo();
    endtask

    initial
    begin
        seed      = 32'h0aeb4de6;
        errors    = 0;
        checks    = 0;
        waits     = 0;
        errBefore = 0;
        rst       = 1'b1;
        pSel      = 1'b0;
        pEnable   = 1'b0;
        pWrite    = 1'b0;
        pAddr     = '0;
        pWData    = '0;
        expRData  = '0;
        expErr    = 1'b0;
        checkRead = 1'b0;
        hiM       = '0;
        loM       = '0;
        for (int r = 0; r < 32; r++)
            model[r] = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        regTest();
        endTest("registers");
        aluTest();
        endTest("rtype");
        immTest();
        endTest("immediate");
        mulTest();
        endTest("multiply");
        hiLoTest();
        endTest("hilo");
        errorTest();
        endTest("errors");

        @(negedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule
